// ==== clkgen_config.svh ====
// clock-enable generator parameters
`ifndef CLKGEN_CONFIG_SVH
`define CLKGEN_CONFIG_SVH

// ##############################
// channel bank
// ##############################
`define CLKGEN_NUM_CHAN 7

// cycles that locked stays low after reset or relock
`define CLKGEN_LOCK_CYCLES 16

// ##############################
// register port
// ##############################
`define CLKGEN_ADDR_W 7  // same as DADDR
`define CLKGEN_DATA_W 16 // same as DI / DO

// read-only status, bit 0 is locked
`define CLKGEN_STATUS_ADDR 7

`endif

// ==== clkgen_pkg.sv ====
// clock-enable generator types
`include "clkgen_config.svh"

package clkgen_pkg;

  // ##############################
  // channel setting
  // ##############################

  // one register word: div in the low byte, phase in the high byte
  typedef struct packed {
    logic [7:0] phase; // tick offset in cycles
    logic [7:0] div;   // divide value minus one
  } chan_cfg_t;

  // whole bank, register file to divider bank
  typedef chan_cfg_t [`CLKGEN_NUM_CHAN-1:0] chan_cfg_arr_t;

  // ##############################
  // register port
  // ##############################

  typedef struct packed {
    logic [`CLKGEN_ADDR_W-1:0] addr;
    logic                      we;    // write when high
    logic [`CLKGEN_DATA_W-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic [`CLKGEN_DATA_W-1:0] rdata;
    logic                      err;   // bad address
  } cfg_resp_t;

endpackage

// ==== rr_skid_buffer.sv ====
// two-entry valid/ready buffer
module rr_skid_buffer #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     CLKIN1,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t out_q;        // main entry, drives the output
  payload_t skid_q;       // second entry, catches a word during stall
  logic     out_valid_q;
  logic     skid_valid_q;
  logic     in_ready_q;
  logic     skid_valid_d;
  logic     in_fire;
  logic     out_free;

  assign in_fire  = in_valid & in_ready_q;
  assign out_free = out_ready | ~out_valid_q; // main entry drains or is empty

  always_comb
  begin
    skid_valid_d = skid_valid_q;
    if (out_free)
      skid_valid_d = 1'b0;       // skid word moves to main
    else if (in_fire)
      skid_valid_d = 1'b1;       // stalled, park the new word
  end

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;
    end
    else
    begin
      if (out_free)
        out_valid_q <= skid_valid_q | in_fire;
      skid_valid_q <= skid_valid_d;
      in_ready_q   <= ~skid_valid_d; // registered ready
    end
  end

  // payload path
  always_ff @(posedge CLKIN1)
  begin
    if (out_free && (skid_valid_q || in_fire))
      out_q <= skid_valid_q ? skid_q : in_data;
    if (!out_free && in_fire)
      skid_q <= in_data;
  end

  assign in_ready  = in_ready_q;
  assign out_data  = out_q;
  assign out_valid = out_valid_q;

endmodule

// ==== cfg_reg_file.sv ====
// channel setting registers
`include "clkgen_config.svh"

module cfg_reg_file (
  input  logic                     CLKIN1,
  input  logic                     reset,
  input  clkgen_pkg::cfg_req_t     req,
  input  logic                     req_valid,
  output logic                     req_ready,
  output clkgen_pkg::cfg_resp_t    resp,
  output logic                     resp_valid,
  input  logic                     resp_ready,
  input  logic                     locked,
  output clkgen_pkg::chan_cfg_arr_t chan_cfg,
  output logic                     relock
);

  localparam int SEL_W = $clog2(`CLKGEN_NUM_CHAN);

  clkgen_pkg::chan_cfg_arr_t chan_q;
  logic [SEL_W-1:0]          sel;
  logic                      take;
  logic                      is_chan;
  logic                      is_status;

  // ##############################
  // decode
  // ##############################

  // one request in, one response out, same cycle
  assign take      = req_valid & resp_ready;
  assign sel       = req.addr[SEL_W-1:0];
  assign is_chan   = req.addr < `CLKGEN_ADDR_W'(`CLKGEN_NUM_CHAN);
  assign is_status = req.addr == `CLKGEN_ADDR_W'(`CLKGEN_STATUS_ADDR);

  assign req_ready  = resp_ready;
  assign resp_valid = req_valid;
  assign relock     = take & req.we & is_chan; // any channel write relocks

  // ##############################
  // channel registers
  // ##############################

  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      // channel i starts at divide by 2**i
      for (int i = 0; i < `CLKGEN_NUM_CHAN; i++)
      begin
        chan_q[i].div   <= 8'((1 << i) - 1);
        chan_q[i].phase <= 8'd0;
      end
    end
    else if (take && req.we && is_chan)
    begin
      chan_q[sel] <= req.wdata;
    end
  end

  // ##############################
  // response
  // ##############################

  always_comb
  begin
    resp = '0;
    if (is_chan)
      resp.rdata = req.we ? req.wdata : chan_q[sel]; // write echoes new value
    else if (is_status)
      resp.rdata = `CLKGEN_DATA_W'(locked);           // writes here are dropped
    else
      resp.err = 1'b1;
  end

  assign chan_cfg = chan_q;

endmodule

// ==== lock_monitor.sv ====
// lock counter
`include "clkgen_config.svh"

module lock_monitor (
  input  logic CLKIN1,
  input  logic reset,
  input  logic relock,
  output logic locked
);

  localparam int LOCK_W = $clog2(`CLKGEN_LOCK_CYCLES + 1);

  logic [LOCK_W-1:0] count_q;

  // loaded on reset and on every relock, runs down to zero
  always_ff @(posedge CLKIN1 or posedge reset)
  begin
    if (reset)
    begin
      count_q <= LOCK_W'(`CLKGEN_LOCK_CYCLES);
    end
    else if (relock)
    begin
      count_q <= LOCK_W'(`CLKGEN_LOCK_CYCLES); // restart even mid-count
    end
    else if (!locked)
    begin
      count_q <= count_q - LOCK_W'(1);
    end
  end

  // low for exactly LOCK_CYCLES cycles after a load
  assign locked = (count_q == '0);

endmodule

// ==== clk_div_bank.sv ====
// divider bank with phase offsets
`include "clkgen_config.svh"

module clk_div_bank (
  input  logic                      CLKIN1,
  input  logic                      reset,
  input  logic                      locked,
  input  clkgen_pkg::chan_cfg_arr_t chan_cfg,
  output logic [`CLKGEN_NUM_CHAN-1:0] tick
);

  logic [7:0] cnt_q [`CLKGEN_NUM_CHAN];

  // ##############################
  // per-channel counters
  // ##############################

  genvar i;
  generate
    for (i = 0; i < `CLKGEN_NUM_CHAN; i++)
    begin : gen_chan
      logic wrap;

      assign wrap = (cnt_q[i] >= chan_cfg[i].div); // last cycle of the period

      always_ff @(posedge CLKIN1 or posedge reset)
      begin
        if (reset)
        begin
          cnt_q[i] <= 8'd0;
        end
        else if (!locked)
        begin
          cnt_q[i] <= 8'd0; // count starts at the first locked cycle
        end
        else if (wrap)
        begin
          cnt_q[i] <= 8'd0;
        end
        else
        begin
          cnt_q[i] <= cnt_q[i] + 8'd1;
        end
      end

      // one-cycle enable at the phase offset
      // phase above div never matches, so the channel stays quiet
      assign tick[i] = locked & (cnt_q[i] == chan_cfg[i].phase);
    end
  endgenerate

endmodule

// ==== clkgen_top.sv ====
// clock-enable generator top
`include "clkgen_config.svh"

module clkgen_top (
  input  logic                        CLKIN1,
  input  logic                        reset,
  input  clkgen_pkg::cfg_req_t        req,
  input  logic                        req_valid,
  output logic                        req_ready,
  output clkgen_pkg::cfg_resp_t       resp,
  output logic                        resp_valid,
  input  logic                        resp_ready,
  output logic [`CLKGEN_NUM_CHAN-1:0] tick,
  output logic                        locked
);

  clkgen_pkg::cfg_req_t      req_q;      // request buffer to register file
  logic                      req_q_valid;
  logic                      req_q_ready;
  clkgen_pkg::cfg_resp_t     resp_d;     // register file to response buffer
  logic                      resp_d_valid;
  logic                      resp_d_ready;
  clkgen_pkg::chan_cfg_arr_t chan_cfg;
  logic                      relock;

  // ##############################
  // input side
  // ##############################

  rr_skid_buffer #(
    .payload_t (clkgen_pkg::cfg_req_t)
  ) req_buf (
    .CLKIN1    (CLKIN1),
    .reset     (reset),
    .in_data   (req),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .out_data  (req_q),
    .out_valid (req_q_valid),
    .out_ready (req_q_ready)
  );

  // ##############################
  // processing
  // ##############################

  cfg_reg_file cfg_reg_file_inst (
    .CLKIN1     (CLKIN1),
    .reset      (reset),
    .req        (req_q),
    .req_valid  (req_q_valid),
    .req_ready  (req_q_ready),
    .resp       (resp_d),
    .resp_valid (resp_d_valid),
    .resp_ready (resp_d_ready),
    .locked     (locked),
    .chan_cfg   (chan_cfg),
    .relock     (relock)
  );

  lock_monitor lock_monitor_inst (
    .CLKIN1 (CLKIN1),
    .reset  (reset),
    .relock (relock),
    .locked (locked)
  );

  clk_div_bank clk_div_bank_inst (
    .CLKIN1   (CLKIN1),
    .reset    (reset),
    .locked   (locked),
    .chan_cfg (chan_cfg),
    .tick     (tick)
  );

  // ##############################
  // output side
  // ##############################

  rr_skid_buffer #(
    .payload_t (clkgen_pkg::cfg_resp_t)
  ) resp_buf (
    .CLKIN1    (CLKIN1),
    .reset     (reset),
    .in_data   (resp_d),
    .in_valid  (resp_d_valid),
    .in_ready  (resp_d_ready),
    .out_data  (resp),
    .out_valid (resp_valid),
    .out_ready (resp_ready)
  );

endmodule

// ==== tb_clkgen.sv ====
// clock-enable generator testbench
`include "clkgen_config.svh"

module tb_clkgen;

  localparam int SEED        = 83;
  localparam int HS_LIMIT    = 200;  // cycles to wait for req_ready
  localparam int LOCK_LIMIT  = 4 * `CLKGEN_LOCK_CYCLES;
  localparam int DRAIN_LIMIT = 500;

  logic                        CLKIN1 = 1'b0;
  logic                        reset;
  clkgen_pkg::cfg_req_t        req;
  logic                        req_valid;
  logic                        req_ready;
  clkgen_pkg::cfg_resp_t       resp;
  logic                        resp_valid;
  logic                        resp_ready;
  logic [`CLKGEN_NUM_CHAN-1:0] tick;
  logic                        locked;

  logic [31:0] stim_rng  = 32'(SEED);
  logic [31:0] stall_rng = 32'(SEED) ^ 32'h5bd1e995; // second stream from the same seed
  logic        stall_mode;
  logic        timed_out = 1'b0;
  int          resp_errs = 0;
  int          tick_errs = 0;
  int          locked_errs = 0;
  int          other_errs = 0;

  // reference model state
  clkgen_pkg::chan_cfg_t chan_m [`CLKGEN_NUM_CHAN];
  clkgen_pkg::cfg_resp_t exp_q [$];      // expected responses in order
  int                    sent_cyc_q [$]; // cycle of each request transfer
  bit                    lat_chk_q [$];  // latency fixed for this request
  clkgen_pkg::cfg_req_t  pend_req;
  logic                  pend_valid;
  int                    lock_cnt;
  int                    since_lock;
  int                    cycle;

  clkgen_top clkgen_top_inst (
    .CLKIN1     (CLKIN1),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .tick       (tick),
    .locked     (locked)
  );

  initial
  begin
    forever #4 CLKIN1 = ~CLKIN1;
  end

  // ##############################
  // random numbers and checks
  // ##############################

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  task automatic check_resp(input clkgen_pkg::cfg_resp_t got, input clkgen_pkg::cfg_resp_t exp);
    if (got !== exp)
    begin
      resp_errs++;
      $display("ERROR resp cycle %0d: got rdata %h err %h, expected rdata %h err %h",
               cycle, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_tick(input logic [`CLKGEN_NUM_CHAN-1:0] got,
                            input logic [`CLKGEN_NUM_CHAN-1:0] exp);
    if (got !== exp)
    begin
      tick_errs++;
      $display("ERROR tick cycle %0d: got %h expected %h", cycle, got, exp);
    end
  endtask

  task automatic check_locked(input logic got, input logic exp);
    if (got !== exp)
    begin
      locked_errs++;
      $display("ERROR locked cycle %0d: got %h expected %h", cycle, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout: %s did not finish in time", what);
    other_errs++;
    timed_out = 1'b1;
  endtask

  // ##############################
  // reference model
  // ##############################

  // sampled mid-cycle, where every DUT output is settled
  always @(negedge CLKIN1)
  begin : model
    logic                        exp_locked;
    logic [`CLKGEN_NUM_CHAN-1:0] exp_tick;
    clkgen_pkg::cfg_resp_t       want;
    clkgen_pkg::cfg_resp_t       formed;
    logic                        relock_now;
    int                          sent_cyc;
    bit                          lat_chk;
    int                          idx;
    if (reset)
    begin
      for (int i = 0; i < `CLKGEN_NUM_CHAN; i++)
      begin
        chan_m[i].div   = 8'((2 ** i) - 1); // divide by 2**i
        chan_m[i].phase = 8'd0;
      end
      exp_q.delete();
      sent_cyc_q.delete();
      lat_chk_q.delete();
      pend_valid = 1'b0;
      lock_cnt   = `CLKGEN_LOCK_CYCLES;
      since_lock = 0;
      cycle      = 0;
      check_locked(locked, 1'b0);
      check_tick(tick, '0);
      if (req_ready || resp_valid)
      begin
        $display("handshake output high during reset");
        other_errs++;
      end
    end
    else
    begin
      exp_locked = (lock_cnt == 0);
      check_locked(locked, exp_locked);
      for (int i = 0; i < `CLKGEN_NUM_CHAN; i++)
        exp_tick[i] = exp_locked &&
                      ((since_lock % (int'(chan_m[i].div) + 1)) == int'(chan_m[i].phase));
      check_tick(tick, exp_tick);

      if (resp_valid && resp_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("cycle %0d: response arrived with no request outstanding", cycle);
          other_errs++;
        end
        else
        begin
          want     = exp_q.pop_front();
          sent_cyc = sent_cyc_q.pop_front();
          lat_chk  = lat_chk_q.pop_front();
          check_resp(resp, want);
          if (lat_chk && (cycle - sent_cyc != 2))
          begin
            $display("cycle %0d: response took %0d cycles instead of 2",
                     cycle, cycle - sent_cyc);
            other_errs++;
          end
        end
      end

      // register file takes last cycle's request
      relock_now = 1'b0;
      if (pend_valid)
      begin
        formed = '0;
        idx    = int'(pend_req.addr);
        if (idx < `CLKGEN_NUM_CHAN)
        begin
          if (pend_req.we)
          begin
            formed.rdata = pend_req.wdata;
            chan_m[idx]  = pend_req.wdata;
            relock_now   = 1'b1;
          end
          else
            formed.rdata = chan_m[idx];
        end
        else if (idx == `CLKGEN_STATUS_ADDR)
          formed.rdata = `CLKGEN_DATA_W'(exp_locked);
        else
          formed.err = 1'b1;
        exp_q.push_back(formed);
        pend_valid = 1'b0;
      end

      if (req_valid && req_ready)
      begin
        pend_valid = 1'b1;
        pend_req   = req;
        sent_cyc_q.push_back(cycle);
        lat_chk_q.push_back(!stall_mode);
      end

      if (exp_locked)
        since_lock++;
      else
        since_lock = 0;
      if (relock_now)
        lock_cnt = `CLKGEN_LOCK_CYCLES;
      else if (lock_cnt != 0)
        lock_cnt--;
      cycle++;
    end
  end

  // ##############################
  // stimulus
  // ##############################

  always @(posedge CLKIN1)
  begin
    if (stall_mode)
    begin
      stall_rng = xorshift32(stall_rng);
      resp_ready <= (stall_rng[3:0] > 4'd4);  // about one stall in three
    end
    else
      resp_ready <= 1'b1;
  end

  // called at a rising edge, returns at the transfer edge
  task automatic send_request(input clkgen_pkg::cfg_req_t r);
    int waited;
    waited = 0;
    if (!timed_out)
    begin
      req       <= r;
      req_valid <= 1'b1;
      @(negedge CLKIN1);
      while (!req_ready && !timed_out)
      begin
        @(negedge CLKIN1);
        waited++;
        if (waited > HS_LIMIT)
          note_timeout("request handshake");
      end
      @(posedge CLKIN1);
      req_valid <= 1'b0;
    end
  endtask

  task automatic wait_locked();
    int waited;
    waited = 0;
    @(negedge CLKIN1);
    while (!locked && !timed_out)
    begin
      @(negedge CLKIN1);
      waited++;
      if (waited > LOCK_LIMIT)
        note_timeout("lock");
    end
    @(posedge CLKIN1);
  endtask

  task automatic drain_responses();
    int waited;
    waited = 0;
    @(posedge CLKIN1);
    while (sent_cyc_q.size() != 0 && !timed_out)
    begin
      @(posedge CLKIN1);
      waited++;
      if (waited > DRAIN_LIMIT)
        note_timeout("response drain");
    end
  endtask

  function automatic clkgen_pkg::cfg_req_t make_request(input bit chan_writes);
    clkgen_pkg::cfg_req_t r;
    logic [31:0]          a;
    logic [31:0]          d;
    a = rand_word();
    d = rand_word();
    if (a[3:0] < 4'd13)
      r.addr = 7'(a[31:8] % 24'd9);  // mostly channels, status and one bad address
    else
      r.addr = a[30:24];
    r.we = (a[7:5] < 3'd3);
    if (!chan_writes && (r.addr < 7'(`CLKGEN_NUM_CHAN)))
      r.we = 1'b0;
    if (d[18:17] == 2'd0)
      r.wdata = d[15:0];
    else
      r.wdata = {4'h0, d[7:4], 4'h0, d[3:0]}; // small div and phase
    return r;
  endfunction

  task automatic run_random(input int count, input bit chan_writes);
    clkgen_pkg::cfg_req_t r;
    logic [31:0]          g;
    int                   gap;
    int                   k;
    for (k = 0; k < count && !timed_out; k++)
    begin
      r = make_request(chan_writes);
      send_request(r);
      g = rand_word();
      if (r.we && (r.addr < 7'(`CLKGEN_NUM_CHAN)))
        gap = 20 + int'(g[5:0]);   // let ticks run after a relock
      else if (g[2:0] == 3'd0)
        gap = 8 + int'(g[8:4]);
      else
        gap = int'(g[1:0]);
      repeat (gap) @(posedge CLKIN1);
    end
  endtask

  initial
  begin : stimulus
    clkgen_pkg::cfg_req_t r;
    int                   total;
    reset      <= 1'b1;
    req        <= '0;
    req_valid  <= 1'b0;
    resp_ready <= 1'b1;
    stall_mode <= 1'b0;
    repeat (2) @(posedge CLKIN1);
    reset <= 1'b0;

    // reset values, status and a bad address while still unlocked
    r = '0;
    for (int a = 0; a <= 8; a++)
    begin
      r.addr = 7'(a);
      send_request(r);
    end
    r.addr = 7'h5a;
    send_request(r);
    drain_responses();
    wait_locked();

    // status and bad-address writes keep the lock
    r.addr  = 7'(`CLKGEN_STATUS_ADDR);
    r.we    = 1'b1;
    r.wdata = 16'hffff;
    send_request(r);
    r.addr = 7'h40;
    send_request(r);
    r.addr = 7'(`CLKGEN_STATUS_ADDR);
    r.we   = 1'b0;
    send_request(r);
    drain_responses();

    run_random(120, 1'b1);  // no back-pressure, channel writes allowed
    drain_responses();
    wait_locked();
    stall_mode <= 1'b1;
    run_random(150, 1'b0);  // back-pressure, settings stay fixed
    drain_responses();
    stall_mode <= 1'b0;
    repeat (4) @(posedge CLKIN1);

    total = resp_errs + tick_errs + locked_errs + other_errs;
    $display("errors: resp %0d tick %0d locked %0d other %0d",
             resp_errs, tick_errs, locked_errs, other_errs);
    if (total == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
clkgen_pkg.sv
rr_skid_buffer.sv
cfg_reg_file.sv
lock_monitor.sv
clk_div_bank.sv
clkgen_top.sv
tb_clkgen.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the clock-enable generator testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project directory"
  exit 1
fi

verilator --binary --timing -f list.f --top-module tb_clkgen -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_clkgen)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
